// ==== logic/bchPkg.sv ====
package bchPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// code geometry for BCH(15,5), t=3 over GF(16)
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int codeLen = 15;
	localparam int msgLen = 5;
	localparam int parityLen = codeLen - msgLen;
	localparam int fieldWidth = 4;
	localparam int maxErrors = 3;
	localparam int queueDepth = 2; // also the starting credit count of every sender

	localparam logic [parityLen:0] genPoly = 11'b101_0011_0111; // x^10+x^8+x^5+x^4+x^2+x+1
	localparam logic [fieldWidth:0] primPoly = 5'b1_0011; // x^4+x+1

	// evaluation points of the odd syndromes
	localparam logic [fieldWidth-1:0] alpha1 = 4'h2;
	localparam logic [fieldWidth-1:0] alpha3 = 4'h8;
	localparam logic [fieldWidth-1:0] alpha5 = 4'h6;

	// term j of the locator is multiplied by alpha^-j per Chien step
	localparam logic [maxErrors:0][fieldWidth-1:0] chienStep = {4'hf, 4'hd, 4'h9, 4'h1};

	typedef logic [fieldWidth-1:0] symbolT;
	typedef logic [$clog2(queueDepth + 1)-1:0] creditT;

	typedef struct packed {
		logic [msgLen-1:0] value;
	} msgT;

	typedef struct packed {
		msgT msg;
		logic [codeLen-1:0] error; // bit i flips codeword bit i
	} frameT;

	typedef struct packed {
		symbolT s1;
		symbolT s3;
		symbolT s5;
		logic [codeLen-1:0] word;
	} syndromeT;

	typedef struct packed {
		symbolT [maxErrors:0] coef;
		logic [1:0] degree;
		logic [codeLen-1:0] word;
	} locatorT;

	typedef struct packed {
		logic [msgLen-1:0] msg;
		logic fail;
	} resultT;

	// shift-and-add multiply, reducing by the field polynomial on every carry out
	function automatic symbolT gfMul(input symbolT a, input symbolT b);
		symbolT acc;
		symbolT sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < fieldWidth; i++) begin
			if (b[i])
				acc ^= sh;
			sh = sh[fieldWidth-1] ? ({sh[fieldWidth-2:0], 1'b0} ^ primPoly[fieldWidth-1:0])
				: {sh[fieldWidth-2:0], 1'b0};
		end
		return acc;
	endfunction

endpackage

// ==== logic/creditQueue.sv ====
`timescale 1ns/1ps

module creditQueue #(
	parameter type payloadT = logic,
	parameter int depth = 2
) (
	input logic clk,
	input logic reset,
	input logic push,
	input payloadT pushData,
	input logic pop,
	output payloadT popData,
	output logic notEmpty,
	output logic credit
);

	typedef logic [$clog2(depth)-1:0] ptrT;

	payloadT mem [depth];
	ptrT wrPtr;
	ptrT rdPtr;
	logic [$clog2(depth + 1)-1:0] count;

	function automatic ptrT nextPtr(input ptrT p);
		return (p == ptrT'(depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign popData = mem[rdPtr]; // head is always on the output, pop just advances
	assign notEmpty = count != '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			credit <= pop; // one slot freed, hand it back to the sender
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= pushData;
	end

endmodule

// ==== logic/bchEncoder.sv ====
`timescale 1ns/1ps

module bchEncoder (
	input logic clk,
	input logic reset,
	input logic notEmpty,
	input bchPkg::frameT popData,
	output logic pop,
	input logic downCredit,
	output logic codeBit,
	output logic errorBit,
	output logic bitValid,
	output logic frameStart
);

	logic busy;
	logic [3:0] bitCnt;
	bchPkg::creditT credits; // free slots left in the syndrome queue
	logic [bchPkg::parityLen-1:0] parityReg;
	logic [bchPkg::msgLen-1:0] msgReg;
	logic [bchPkg::codeLen-1:0] errShift;

	// generator LFSR run over the whole message, giving m(x)*x^10 mod g(x)
	function automatic logic [bchPkg::parityLen-1:0] parityOf(input logic [bchPkg::msgLen-1:0] m);
		logic [bchPkg::parityLen-1:0] rem;
		logic feedback;
		rem = '0;
		for (int i = bchPkg::msgLen - 1; i >= 0; i--) begin
			feedback = m[i] ^ rem[bchPkg::parityLen-1];
			rem = {rem[bchPkg::parityLen-2:0], 1'b0};
			if (feedback)
				rem ^= bchPkg::genPoly[bchPkg::parityLen-1:0];
		end
		return rem;
	endfunction

	// the serial stream cannot stall, so the syndrome slot is reserved before starting
	assign pop = !busy && notEmpty && credits != '0;

	// parity sits in the high bits of the codeword, so it goes out first
	assign codeBit = (bitCnt < 4'(bchPkg::parityLen)) ? parityReg[bchPkg::parityLen-1]
		: msgReg[bchPkg::msgLen-1];
	assign errorBit = errShift[bchPkg::codeLen-1];
	assign bitValid = busy;
	assign frameStart = busy && bitCnt == 4'd0;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			bitCnt <= 4'd0;
			credits <= bchPkg::creditT'(bchPkg::queueDepth);
		end else begin
			credits <= credits + bchPkg::creditT'(downCredit) - bchPkg::creditT'(pop);
			if (pop) begin
				busy <= 1'b1;
				bitCnt <= 4'd0;
			end else if (busy) begin
				bitCnt <= bitCnt + 1'b1;
				if (bitCnt == 4'(bchPkg::codeLen - 1))
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			parityReg <= parityOf(popData.msg.value);
			msgReg <= popData.msg.value;
			errShift <= popData.error;
		end else if (busy) begin
			if (bitCnt < 4'(bchPkg::parityLen))
				parityReg <= {parityReg[bchPkg::parityLen-2:0], 1'b0};
			else
				msgReg <= {msgReg[bchPkg::msgLen-2:0], 1'b0};
			errShift <= {errShift[bchPkg::codeLen-2:0], 1'b0};
		end
	end

endmodule

// ==== logic/bchChannel.sv ====
`timescale 1ns/1ps

module bchChannel (
	input logic clk,
	input logic reset,
	input logic codeBit,
	input logic errorBit,
	input logic bitValid,
	input logic frameStart,
	output logic rxBit,
	output logic rxValid,
	output logic rxStart
);

	// each error bit inverts the code bit passing by on the noisy link
	assign rxBit = codeBit ^ errorBit;
	assign rxValid = bitValid;
	assign rxStart = frameStart;

endmodule

// ==== logic/bchSyndrome.sv ====
`timescale 1ns/1ps

module bchSyndrome (
	input logic clk,
	input logic reset,
	input logic rxBit,
	input logic rxValid,
	input logic rxStart,
	output logic push,
	output bchPkg::syndromeT pushData
);

	logic [3:0] bitCnt;
	logic lastBit;
	bchPkg::symbolT s1;
	bchPkg::symbolT s3;
	bchPkg::symbolT s5;
	bchPkg::symbolT base1;
	bchPkg::symbolT base3;
	bchPkg::symbolT base5;
	bchPkg::symbolT rxSym;
	logic [bchPkg::codeLen-1:0] word;

	// the 15th bit arrives when 14 have already been counted
	assign lastBit = rxValid && !rxStart && bitCnt == 4'(bchPkg::codeLen - 1);

	// a new frame starts its Horner chain from zero
	assign base1 = rxStart ? '0 : s1;
	assign base3 = rxStart ? '0 : s3;
	assign base5 = rxStart ? '0 : s5;
	assign rxSym = {{(bchPkg::fieldWidth - 1){1'b0}}, rxBit};

	// accumulators hold the final values in the push cycle
	assign pushData = '{s1: s1, s3: s3, s5: s5, word: word};

	always_ff @(posedge clk) begin
		if (reset) begin
			bitCnt <= 4'd0;
			push <= 1'b0;
		end else begin
			push <= lastBit;
			if (rxValid)
				bitCnt <= rxStart ? 4'd1 : bitCnt + 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Horner steps, highest coefficient first
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rxValid) begin
			s1 <= bchPkg::gfMul(base1, bchPkg::alpha1) ^ rxSym;
			s3 <= bchPkg::gfMul(base3, bchPkg::alpha3) ^ rxSym;
			s5 <= bchPkg::gfMul(base5, bchPkg::alpha5) ^ rxSym;
			word <= {word[bchPkg::codeLen-2:0], rxBit}; // first bit ends up in the MSB
		end
	end

endmodule

// ==== logic/bchLocator.sv ====
`timescale 1ns/1ps

module bchLocator (
	input logic clk,
	input logic reset,
	input logic notEmpty,
	input bchPkg::syndromeT popData,
	output logic pop,
	input logic downCredit,
	output logic push,
	output bchPkg::locatorT pushData
);

	typedef enum logic [1:0] {stIdle, stDisc, stUpdate, stFinish} stateT;

	stateT state;
	logic [2:0] round;
	bchPkg::creditT credits;
	logic sendNow;

	bchPkg::symbolT [2 * bchPkg::maxErrors:1] synd;
	bchPkg::symbolT [bchPkg::maxErrors:0] lambda;
	bchPkg::symbolT [bchPkg::maxErrors:0] bPoly;
	bchPkg::symbolT [bchPkg::maxErrors:0] shiftedB;
	bchPkg::symbolT [bchPkg::maxErrors:0] lambdaNext;
	bchPkg::symbolT gamma;
	bchPkg::symbolT delta;
	bchPkg::symbolT discrepancy;
	bchPkg::symbolT s2;
	logic signed [3:0] k;
	logic [bchPkg::codeLen-1:0] word;
	logic [1:0] degree;

	assign pop = state == stIdle && notEmpty;
	assign sendNow = state == stFinish && credits != '0;
	assign s2 = bchPkg::gfMul(popData.s1, popData.s1); // even syndromes are squares in GF(2^m)
	assign shiftedB = {bPoly[bchPkg::maxErrors-1:0], 4'h0};

	// discrepancy of round r is sum of lambda_i * S(r+1-i)
	always_comb begin
		discrepancy = '0;
		for (int i = 0; i <= bchPkg::maxErrors; i++) begin
			if (i <= int'(round))
				discrepancy ^= bchPkg::gfMul(lambda[i], synd[int'(round) + 1 - i]);
		end
	end

	// the inversionless update leaves lambda scaled by a nonzero constant
	always_comb begin
		for (int j = 0; j <= bchPkg::maxErrors; j++)
			lambdaNext[j] = bchPkg::gfMul(gamma, lambda[j]) ^ bchPkg::gfMul(delta, shiftedB[j]);
	end

	always_comb begin
		degree = 2'd0;
		for (int j = 1; j <= bchPkg::maxErrors; j++) begin
			if (lambda[j] != '0)
				degree = 2'(j);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
			round <= 3'd0;
			credits <= bchPkg::creditT'(bchPkg::queueDepth);
			push <= 1'b0;
		end else begin
			push <= sendNow;
			credits <= credits + bchPkg::creditT'(downCredit) - bchPkg::creditT'(sendNow);
			case (state)
				stIdle: begin
					round <= 3'd0;
					if (pop)
						state <= stDisc;
				end
				stDisc: state <= stUpdate;
				stUpdate: begin
					round <= round + 1'b1;
					state <= (round == 3'(2 * bchPkg::maxErrors - 1)) ? stFinish : stDisc;
				end
				stFinish: if (sendNow) state <= stIdle; // hold until locQueue has room
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			synd <= {bchPkg::gfMul(popData.s3, popData.s3), popData.s5,
				bchPkg::gfMul(s2, s2), popData.s3, s2, popData.s1};
			lambda <= {12'h000, 4'h1};
			bPoly <= {12'h000, 4'h1};
			gamma <= 4'h1;
			k <= 4'sd0;
			word <= popData.word;
		end
		if (state == stDisc)
			delta <= discrepancy;
		if (state == stUpdate) begin
			lambda <= lambdaNext;
			if (delta != '0 && !k[3]) begin
				bPoly <= lambda;
				gamma <= delta;
				k <= -k - 4'sd1;
			end else begin
				bPoly <= shiftedB;
				k <= k + 4'sd1;
			end
		end
		if (sendNow)
			pushData <= '{coef: lambda, degree: degree, word: word};
	end

endmodule

// ==== logic/bchChien.sv ====
`timescale 1ns/1ps

module bchChien (
	input logic clk,
	input logic reset,
	input logic notEmpty,
	input bchPkg::locatorT popData,
	output logic pop,
	input logic outCredit,
	output logic outValid,
	output logic [bchPkg::msgLen-1:0] outMsg,
	output logic outFail
);

	typedef enum logic [1:0] {stIdle, stSearch, stSend} stateT;

	stateT state;
	logic [3:0] outCredits; // granted by the caller, none after reset
	logic sendNow;
	logic [3:0] pos;
	logic [3:0] roots;
	logic isRoot;
	bchPkg::symbolT [bchPkg::maxErrors:0] terms;
	logic [1:0] degree;
	logic [bchPkg::codeLen-1:0] word;
	bchPkg::resultT result;

	assign pop = state == stIdle && notEmpty;
	assign sendNow = state == stSend && outCredits != 4'd0;
	assign isRoot = (terms[0] ^ terms[1] ^ terms[2] ^ terms[3]) == '0;

	assign outMsg = result.msg;
	assign outFail = result.fail;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
			outCredits <= 4'd0;
			outValid <= 1'b0;
		end else begin
			outValid <= sendNow;
			outCredits <= outCredits + {3'b000, outCredit} - {3'b000, sendNow};
			case (state)
				stIdle: if (pop) state <= stSearch;
				stSearch: if (pos == 4'(bchPkg::codeLen - 1)) state <= stSend;
				stSend: if (sendNow) state <= stIdle;
				default: state <= stIdle;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// position i is in error when lambda(alpha^-i) is zero
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (pop) begin
			terms <= popData.coef;
			degree <= popData.degree;
			word <= popData.word;
			pos <= 4'd0;
			roots <= 4'd0;
		end else if (state == stSearch) begin
			if (isRoot) begin
				word[pos] <= ~word[pos];
				roots <= roots + 1'b1;
			end
			for (int j = 0; j <= bchPkg::maxErrors; j++)
				terms[j] <= bchPkg::gfMul(terms[j], bchPkg::chienStep[j]);
			pos <= pos + 1'b1;
		end
		if (sendNow) begin
			result.msg <= word[bchPkg::msgLen-1:0]; // message occupies the low bits
			result.fail <= roots != {2'b00, degree}; // too many errors leave roots missing
		end
	end

endmodule

// ==== logic/bchCodec.sv ====
`timescale 1ns/1ps

module bchCodec (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [bchPkg::msgLen-1:0] msg,
	input logic [bchPkg::codeLen-1:0] error,
	output logic inCredit,
	input logic outCredit,
	output logic outValid,
	output logic [bchPkg::msgLen-1:0] outMsg,
	output logic outFail
);

	bchPkg::frameT msgData;
	logic msgNotEmpty, msgPop;
	logic codeBit, errorBit, bitValid, frameStart;
	logic rxBit, rxValid, rxStart;
	bchPkg::syndromeT syndIn, syndOut;
	logic syndPush, syndPop, syndNotEmpty, syndCredit;
	bchPkg::locatorT locIn, locOut;
	logic locPush, locPop, locNotEmpty, locCredit;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// encoder side, frames carry their own error pattern
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	creditQueue #(.payloadT(bchPkg::frameT), .depth(bchPkg::queueDepth)) u_msgQueue (
		.clk(clk), .reset(reset), .push(inValid), .pushData({msg, error}), .pop(msgPop),
		.popData(msgData), .notEmpty(msgNotEmpty), .credit(inCredit));

	bchEncoder u_bchEncoder (
		.clk(clk), .reset(reset), .notEmpty(msgNotEmpty), .popData(msgData), .pop(msgPop),
		.downCredit(syndCredit), .codeBit(codeBit), .errorBit(errorBit),
		.bitValid(bitValid), .frameStart(frameStart));

	bchChannel u_bchChannel (
		.clk(clk), .reset(reset), .codeBit(codeBit), .errorBit(errorBit),
		.bitValid(bitValid), .frameStart(frameStart),
		.rxBit(rxBit), .rxValid(rxValid), .rxStart(rxStart));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decoder side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	bchSyndrome u_bchSyndrome (
		.clk(clk), .reset(reset), .rxBit(rxBit), .rxValid(rxValid), .rxStart(rxStart),
		.push(syndPush), .pushData(syndIn));

	// its credits go back to the encoder, which owns the syndrome-side budget
	creditQueue #(.payloadT(bchPkg::syndromeT), .depth(bchPkg::queueDepth)) u_syndQueue (
		.clk(clk), .reset(reset), .push(syndPush), .pushData(syndIn), .pop(syndPop),
		.popData(syndOut), .notEmpty(syndNotEmpty), .credit(syndCredit));

	bchLocator u_bchLocator (
		.clk(clk), .reset(reset), .notEmpty(syndNotEmpty), .popData(syndOut), .pop(syndPop),
		.downCredit(locCredit), .push(locPush), .pushData(locIn));

	creditQueue #(.payloadT(bchPkg::locatorT), .depth(bchPkg::queueDepth)) u_locQueue (
		.clk(clk), .reset(reset), .push(locPush), .pushData(locIn), .pop(locPop),
		.popData(locOut), .notEmpty(locNotEmpty), .credit(locCredit));

	bchChien u_bchChien (
		.clk(clk), .reset(reset), .notEmpty(locNotEmpty), .popData(locOut), .pop(locPop),
		.outCredit(outCredit), .outValid(outValid), .outMsg(outMsg), .outFail(outFail));

endmodule

// ==== test/codecModel.svh ====
`ifndef codecModelSvh
`define codecModelSvh

// number of codeword bits that the channel flips
function automatic int errorWeight(input logic [bchPkg::codeLen-1:0] pattern);
	int weight;
	weight = 0;
	for (int i = 0; i < bchPkg::codeLen; i++)
		weight += int'(pattern[i]);
	return weight;
endfunction

// a t=3 code gets the message back whenever three or fewer bits flip
function automatic bit isCorrectable(input logic [bchPkg::codeLen-1:0] pattern);
	return errorWeight(pattern) <= bchPkg::maxErrors;
endfunction

// decoder answer for a frame, only defined for correctable patterns
function automatic bchPkg::resultT expectedResult(input logic [bchPkg::msgLen-1:0] sentMsg,
	input logic [bchPkg::codeLen-1:0] pattern);
	bchPkg::resultT result;
	result.msg = sentMsg; // systematic code, the message bits come out unchanged
	result.fail = !isCorrectable(pattern);
	return result;
endfunction

`endif

// ==== test/codecTb.sv ====
`timescale 1ns/1ps

module codecTb;

	localparam int frameCount = 80;
	localparam int sendTimeout = 300; // cycles allowed between two accepted frames
	localparam int drainTimeout = 2000;

	logic clk;
	logic reset;
	logic inValid;
	logic [bchPkg::msgLen-1:0] msg;
	logic [bchPkg::codeLen-1:0] error;
	logic inCredit;
	logic outCredit;
	logic outValid;
	logic [bchPkg::msgLen-1:0] outMsg;
	logic outFail;

	logic [31:0] lfsrState;
	bchPkg::frameT sentQ[$]; // frames in flight with the oldest first
	int inCredits;
	int outstanding; // output credits granted and not yet used by outValid
	int framesSent;
	int creditPulses;
	logic grantEnable;

	`include "codecModel.svh"

	bchCodec u_bchCodec (
		.clk(clk), .reset(reset), .inValid(inValid), .msg(msg), .error(error),
		.inCredit(inCredit), .outCredit(outCredit), .outValid(outValid),
		.outMsg(outMsg), .outFail(outFail));

	always #10 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// random source
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1
	endfunction

	function automatic int randBits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | int'(lfsrState[0]);
			lfsrState = galoisStep(lfsrState);
		end
		return value;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	// outputs only move on the rising edge, so the falling edge sees them settled
	task automatic sampleOutputs();
		bchPkg::frameT sentFrame;
		bchPkg::resultT want;
		if (inCredit) begin
			creditPulses++;
			inCredits++;
			assert (creditPulses <= framesSent)
			else failRun($sformatf("inCredit pulse %0d seen with only %0d frames sent",
				creditPulses, framesSent));
		end
		if (outValid) begin
			assert (outstanding > 0)
			else failRun("outValid rose while no output credit was outstanding");
			assert (sentQ.size() > 0)
			else failRun("outValid came out with no frame in flight");
			outstanding--;
			sentFrame = sentQ.pop_front();
			if (isCorrectable(sentFrame.error)) begin
				want = expectedResult(sentFrame.msg.value, sentFrame.error);
				assert (outMsg == want.msg)
				else failRun($sformatf("ERROR t=%0t outMsg got %h expected %h",
					$time, outMsg, want.msg));
				assert (outFail == want.fail)
				else failRun($sformatf("ERROR t=%0t outFail got %b expected %b",
					$time, outFail, want.fail));
			end
		end
	endtask

	task automatic stepCycle();
		@(negedge clk);
		sampleOutputs();
		inValid = 1'b0;
		outCredit = 1'b0;
		if (grantEnable && outstanding < bchPkg::queueDepth && randBits(1) == 1) begin
			outCredit = 1'b1;
			outstanding++;
		end
	endtask

	task automatic applyReset();
		reset = 1'b1;
		grantEnable = 1'b0;
		inValid = 1'b0;
		outCredit = 1'b0;
		sentQ.delete();
		inCredits = bchPkg::queueDepth;
		outstanding = 0;
		framesSent = 0;
		creditPulses = 0;
		repeat (8) stepCycle();
		reset = 1'b0;
		grantEnable = 1'b1;
	endtask

	task automatic sendFrames(input int count, input bit correctableOnly);
		bchPkg::frameT frame;
		int weight;
		int pos;
		int guard;
		int cycles;
		int done;
		done = 0;
		cycles = 0;
		while (done < count) begin
			stepCycle();
			cycles++;
			assert (cycles < sendTimeout)
			else failRun("timed out waiting for an input credit");
			if (inCredits > 0 && randBits(1) == 1) begin
				weight = randBits(3) % 6;
				if (correctableOnly && weight > bchPkg::maxErrors)
					weight = bchPkg::maxErrors;
				msg = 5'(randBits(5));
				error = '0;
				guard = 0;
				while (errorWeight(error) < weight && guard < 100) begin
					pos = randBits(4);
					if (pos < bchPkg::codeLen)
						error[pos] = 1'b1; // position 15 is outside the word and is drawn again
					guard++;
				end
				inValid = 1'b1;
				frame.msg.value = msg;
				frame.error = error;
				sentQ.push_back(frame);
				inCredits--;
				framesSent++;
				done++;
				cycles = 0;
			end
		end
	endtask

	task automatic waitForDrain();
		int cycles;
		cycles = 0;
		while (sentQ.size() > 0) begin
			stepCycle();
			cycles++;
			assert (cycles < drainTimeout)
			else failRun("timed out waiting for outValid on the frames in flight");
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		msg = '0;
		error = '0;
		outCredit = 1'b0;
		lfsrState = 32'h815234ef;
		applyReset();

		sendFrames(frameCount, 1'b0);
		waitForDrain();

		// leave frames inside the pipeline and reset under them
		sendFrames(4, 1'b0);
		repeat (25) stepCycle();
		applyReset();
		repeat (60) stepCycle(); // credits still flow here, yet nothing may come out
		sendFrames(1, 1'b1);
		waitForDrain();

		$display("Everything OK");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+test
logic/bchPkg.sv
logic/creditQueue.sv
logic/bchEncoder.sv
logic/bchChannel.sv
logic/bchSyndrome.sv
logic/bchLocator.sv
logic/bchChien.sv
logic/bchCodec.sv
test/codecTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the BCH codec testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module codecTb -f list.f -o codecSim
./obj_dir/codecSim 2>&1 | tee sim.log

if grep -qx "Everything OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed" >&2
	exit 1
fi
